//--- files.f
design/sensor_hub_pkg.sv
design/uart_rx.sv
design/ads1292_spi.sv
design/sensor_core.sv
design/uart_tx.sv
design/sensor_hub_top.sv
testbench/ads1292_model.sv
testbench/tb_sensor_hub.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sensor_hub
RTL_TOP   = sensor_hub_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Finished with no errors" $(LOG) || (echo "Simulation ended early"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_sensor_hub.sv
// Sensor hub testbench, host UART commands and ADS1292 frames with directed checks
`timescale 1ns/1ps

module tb_sensor_hub import sensor_hub_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 40000;              // All tests with a wide margin
	localparam int BYTE_CYCLES    = 10 * CLKS_PER_BIT;  // One 8N1 character
	localparam int REPLY_WAIT     = BYTE_CYCLES + 40;   // Command start to reply start bit
	localparam int QUIET_WAIT     = BYTE_CYCLES + 400;
	localparam int FRAME_WAIT     = 600;                // DRDY to first frame byte
	localparam int DRDY_SPACING   = 2000;
	localparam int OVERRUN_DELAY  = 600;

	logic   clk;
	logic   reset;
	logic   uart_rxd;
	logic   uart_txd;
	logic   spi_miso;
	logic   spi_clk;
	logic   spi_mosi;
	logic   spi_csn;
	logic   ads_drdy_n;
	logic   ads_start;
	logic   ads_reset_n;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	integer seed   = 32'hbd93;

	sensor_hub_top uut (
		.i_clk         (clk),
		.i_reset       (reset),
		.i_uart_rxd    (uart_rxd),
		.i_spi_miso    (spi_miso),
		.i_ads_drdy_n  (ads_drdy_n),
		.o_uart_txd    (uart_txd),
		.o_spi_clk     (spi_clk),
		.o_spi_mosi    (spi_mosi),
		.o_spi_csn     (spi_csn),
		.o_ads_start   (ads_start),
		.o_ads_reset_n (ads_reset_n)
	);

	ads1292_model model (
		.i_spi_clk  (spi_clk),
		.i_spi_csn  (spi_csn),
		.o_drdy_n   (ads_drdy_n),
		.o_spi_miso (spi_miso)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;  // 4 ns period

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// ======================================================================
	// Timing and UART helpers
	// ======================================================================
	task automatic next_cycle();  // Drive and sample point, 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic send_byte(input logic [7:0] data);
		logic [9:0] bits;
		int         i;
		bits = {1'b1, data, 1'b0};  // Stop, data LSB first, start
		for (i = 0; i < 10; i++) begin
			uart_rxd = bits[i];
			wait_cycles(CLKS_PER_BIT);
		end
	endtask

	// Valid stays low if no start bit shows up in time
	task automatic recv_byte(input int max_wait, output uart_byte_t b);
		logic [7:0] data;
		int         waited;
		int         i;
		b      = '0;
		data   = '0;
		waited = 0;
		while (uart_txd && waited < max_wait) begin
			next_cycle();
			waited++;
		end
		if (!uart_txd) begin
			wait_cycles(CLKS_PER_BIT / 2);  // Middle of start bit
			if (!uart_txd) begin
				for (i = 0; i < 8; i++) begin
					wait_cycles(CLKS_PER_BIT);
					data[i] = uart_txd;
				end
				wait_cycles(CLKS_PER_BIT);
				b.valid = uart_txd;  // Stop bit must be high
				b.data  = data;
			end
		end
	endtask

	function automatic uart_byte_t valid_byte(input logic [7:0] data);
		return '{valid: 1'b1, data: data};
	endfunction

	function automatic logic [FRAME_BITS-1:0] random_frame();
		logic [95:0] r;
		r = {$random(seed), $random(seed), $random(seed)};
		return r[FRAME_BITS-1:0];
	endfunction

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected valid %b data %h, got valid %b data %h",
				$time, name, exp.valid, exp.data, got.valid, got.data);
		end
	endtask

	task automatic check_frame(input string name, input logic [FRAME_BITS-1:0] got,
			input logic [FRAME_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	// Status command and its one byte answer
	task automatic query_status(input string name, input logic [7:0] exp);
		uart_byte_t got;
		fork
			send_byte(CMD_STATUS);
			recv_byte(REPLY_WAIT, got);
		join
		check_byte(name, got, valid_byte(exp));
	endtask

	// Nine bytes MSB first
	task automatic recv_frame(input string name, input logic [FRAME_BITS-1:0] exp);
		uart_byte_t            b;
		logic [FRAME_BITS-1:0] got;
		int                    i;
		got = '0;
		for (i = 0; i < FRAME_BYTES; i++) begin
			recv_byte((i == 0) ? FRAME_WAIT : 2 * CLKS_PER_BIT, b);
			if (!b.valid) begin
				errors++;
				$display("%s: byte %0d of %0d never arrived on the UART line",
					name, i, FRAME_BYTES);
				break;
			end
			got = {got[FRAME_BITS-9:0], b.data};
		end
		check_frame(name, got, exp);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("%s: passed, core %s", name, uut.sensor_core.state.name());
		else
			$display("%s: failed with %0d errors, core %s", name, errors - errors_before,
				uut.sensor_core.state.name());
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic test_idle_after_reset();
		logic csn_high;
		check_level("o_uart_txd", uart_txd, 1'b1);
		check_level("o_spi_csn", spi_csn, 1'b1);
		check_level("o_ads_reset_n", ads_reset_n, 1'b1);
		check_level("o_ads_start", ads_start, 1'b0);
		check_level("o_spi_clk", spi_clk, 1'b0);
		check_level("o_spi_mosi", spi_mosi, 1'b0);
		csn_high = 1'b1;
		model.pulse_drdy();  // Run is low, no read expected
		repeat (50) begin
			next_cycle();
			csn_high &= spi_csn;
		end
		check_level("o_spi_csn while stopped", csn_high, 1'b1);
	endtask

	task automatic test_status_and_unknown();
		uart_byte_t got;
		fork
			send_byte(8'h55);
			recv_byte(QUIET_WAIT, got);
		join
		check_byte("reply to 55h", got, '0);
		query_status("status after reset", 8'h00);
	endtask

	task automatic test_chip_reset();
		int waited;
		int low_cycles;
		waited     = 0;
		low_cycles = 0;
		fork
			send_byte(CMD_RESET);
			begin
				while (ads_reset_n && waited < REPLY_WAIT) begin
					next_cycle();
					waited++;
				end
				while (!ads_reset_n && low_cycles <= RESET_CYCLES + 10) begin
					low_cycles++;
					next_cycle();
				end
			end
		join
		check_count("o_ads_reset_n low cycles", low_cycles, RESET_CYCLES);
		query_status("status after chip reset", 8'h00);
	endtask

	task automatic test_frame_streaming();
		logic [FRAME_BITS-1:0] frame_a;
		logic [FRAME_BITS-1:0] frame_b;
		int                    t0;
		send_byte(CMD_START);
		wait_cycles(4);
		check_level("o_ads_start after start", ads_start, 1'b1);
		frame_a = random_frame();
		frame_b = random_frame();
		model.load_frame(frame_a);
		t0 = cycles;
		model.pulse_drdy();
		recv_frame("first frame", frame_a);
		while (cycles - t0 < DRDY_SPACING) next_cycle();
		model.load_frame(frame_b);
		model.pulse_drdy();
		recv_frame("second frame", frame_b);
		wait_cycles(CLKS_PER_BIT);  // Rest of the last stop bit
		query_status("status while running", 8'h80);
	endtask

	task automatic test_overrun_and_stop();
		logic [FRAME_BITS-1:0] frame_a;
		logic [FRAME_BITS-1:0] frame_b;
		uart_byte_t            got;
		int                    t0;
		frame_a = random_frame();
		frame_b = random_frame();
		model.load_frame(frame_a);
		t0 = cycles;
		model.pulse_drdy();
		fork
			recv_frame("frame before overrun", frame_a);
			begin
				while (cycles - t0 < OVERRUN_DELAY) next_cycle();
				model.load_frame(frame_b);
				model.pulse_drdy();  // Lands while frame_a still goes out
			end
		join
		recv_byte(QUIET_WAIT, got);
		check_byte("byte after dropped frame", got, '0);
		send_byte(CMD_STOP);
		wait_cycles(4);
		check_level("o_ads_start after stop", ads_start, 1'b0);
		query_status("status after overrun", 8'h01);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================
	initial begin
		int errors_before;
		uart_rxd = 1'b1;  // Line idle
		reset    = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		errors_before = errors;
		test_idle_after_reset();
		report_test("idle after reset", errors_before);
		errors_before = errors;
		test_status_and_unknown();
		report_test("status and unknown opcode", errors_before);
		errors_before = errors;
		test_chip_reset();
		report_test("chip reset", errors_before);
		errors_before = errors;
		test_frame_streaming();
		report_test("frame streaming", errors_before);
		errors_before = errors;
		test_overrun_and_stop();
		report_test("overrun and stop", errors_before);

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- testbench/ads1292_model.sv
// Behavioral ADS1292 front end that pulses DRDY and shifts a 72-bit frame out on DOUT in SPI mode 1
`timescale 1ns/1ps

module ads1292_model import sensor_hub_pkg::*; (
	input  logic i_spi_clk,
	input  logic i_spi_csn,
	output logic o_drdy_n,
	output logic o_spi_miso
);

	localparam int DRDY_LOW_NS = 16;  // Four system clocks

	logic [FRAME_BITS-1:0] frame;  // Result of the next conversion
	logic [FRAME_BITS-1:0] shreg;  // Bits still to go out MSB first

	initial begin
		o_drdy_n   = 1'b1;  // No data ready
		o_spi_miso = 1'b0;
		frame      = '0;
		shreg      = '0;
	end

	// New conversion result for the next read
	task automatic load_frame(input logic [FRAME_BITS-1:0] data);
		frame = data;
	endtask

	// Active low data ready strobe
	task automatic pulse_drdy();
		o_drdy_n = 1'b0;
		#(DRDY_LOW_NS);
		o_drdy_n = 1'b1;
	endtask

	// CSN fall loads the frame and each rising SCLK puts the next bit on DOUT
	always @(negedge i_spi_csn or posedge i_spi_clk) begin
		if (!i_spi_clk) begin
			shreg      = frame;  // Chip select edge while SCLK idles low
			o_spi_miso = 1'b0;
		end else if (!i_spi_csn) begin
			o_spi_miso = shreg[FRAME_BITS-1];
			shreg      = shreg << 1;
		end
	end

endmodule

//--- design/sensor_hub_top.sv
// Sensor hub top level, UART host link to ADS1292 acquisition path
`timescale 1ns/1ps

module sensor_hub_top import sensor_hub_pkg::*; (
	input  logic i_clk,
	input  logic i_reset,
	input  logic i_uart_rxd,     // From PC
	input  logic i_spi_miso,     // ADS1292 DOUT
	input  logic i_ads_drdy_n,   // ADS1292 data ready, active low
	output logic o_uart_txd,     // To PC
	output logic o_spi_clk,
	output logic o_spi_mosi,
	output logic o_spi_csn,
	output logic o_ads_start,
	output logic o_ads_reset_n
);

	// ======================================================================
	// Internal connections
	// ======================================================================
	uart_byte_t w_rx_byte;   // Host command strobe
	uart_byte_t w_tx_byte;   // Reply or frame byte strobe
	ads_frame_t w_frame;     // Completed SPI frame
	logic       w_run;       // Frame reads enabled
	logic       w_tx_busy;

	uart_rx uart_rx (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_uart_rxd (i_uart_rxd),
		.o_rx_byte  (w_rx_byte)
	);

	ads1292_spi ads1292_spi (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_run        (w_run),
		.i_spi_miso   (i_spi_miso),
		.i_ads_drdy_n (i_ads_drdy_n),
		.o_frame      (w_frame),
		.o_spi_clk    (o_spi_clk),
		.o_spi_mosi   (o_spi_mosi),
		.o_spi_csn    (o_spi_csn)
	);

	sensor_core sensor_core (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_rx_byte     (w_rx_byte),
		.i_frame       (w_frame),
		.i_tx_busy     (w_tx_busy),
		.o_run         (w_run),
		.o_tx_byte     (w_tx_byte),
		.o_ads_start   (o_ads_start),
		.o_ads_reset_n (o_ads_reset_n)
	);

	uart_tx uart_tx (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_tx_byte  (w_tx_byte),
		.o_uart_txd (o_uart_txd),
		.o_tx_busy  (w_tx_busy)
	);

endmodule

//--- design/uart_tx.sv
// UART transmitter, 8N1, busy for the whole ten-bit frame
`timescale 1ns/1ps

module uart_tx import sensor_hub_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  uart_byte_t i_tx_byte,
	output logic       o_uart_txd,
	output logic       o_tx_busy
);

	typedef enum logic {TX_IDLE, TX_SEND} tx_state_e;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_t;

	tx_state_e  state;
	clk_cnt_t   clk_cnt;   // Cycles within current bit
	logic [3:0] bit_cnt;   // 0 start, 1..8 data, 9 stop
	logic [8:0] shreg;     // Data plus stop bit, LSB out first
	logic       txd;
	logic       load;
	logic       bit_end;

	assign load    = (state == TX_IDLE) && i_tx_byte.valid;  // Strobes while busy dropped
	assign bit_end = (clk_cnt == clk_cnt_t'(CLKS_PER_BIT - 1));

	// ======================================================================
	// Bit timing
	// ======================================================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state   <= TX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			txd     <= 1'b1;  // Line idle
		end else begin
			case (state)
				TX_IDLE: begin
					if (load) begin
						txd     <= 1'b0;  // Start bit next cycle
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= TX_SEND;
					end
				end
				TX_SEND: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_cnt == 4'd9) begin  // Stop bit done
							txd   <= 1'b1;
							state <= TX_IDLE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							txd     <= shreg[0];
						end
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Payload shifter, refilled with ones so the stop bit falls out last
	always_ff @(posedge i_clk) begin
		if (load)
			shreg <= {1'b1, i_tx_byte.data};
		else if (state == TX_SEND && bit_end && bit_cnt != 4'd9)
			shreg <= {1'b1, shreg[8:1]};
	end

	assign o_uart_txd = txd;
	assign o_tx_busy  = (state == TX_SEND);  // 10 bit times exactly

endmodule

//--- design/sensor_core.sv
// Sensor core: host command decode, ADS1292 pin control and frame to UART byte sequencing
`timescale 1ns/1ps

module sensor_core import sensor_hub_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  uart_byte_t i_rx_byte,
	input  ads_frame_t i_frame,
	input  logic       i_tx_busy,
	output logic       o_run,
	output uart_byte_t o_tx_byte,
	output logic       o_ads_start,
	output logic       o_ads_reset_n
);

	typedef logic [$clog2(RESET_CYCLES)-1:0]  rst_cnt_t;
	typedef logic [$clog2(FRAME_BYTES+1)-1:0] byte_cnt_t;

	core_state_e           state;
	rst_cnt_t              rst_cnt;      // Chip reset pulse timer
	ads_cmd_e              cmd;
	logic                  cmd_accept;   // Opcode taken this cycle
	logic                  run_lvl;
	logic                  status_req;   // Status reply pending
	logic [6:0]            overrun_cnt;  // Saturating dropped frame count
	logic [FRAME_BITS-1:0] frame_buf;    // Next byte always in the top 8 bits
	byte_cnt_t             byte_cnt;     // Frame bytes left to strobe
	logic                  frame_accept;
	logic                  send_status;
	logic                  send_frame;

	assign cmd        = ads_cmd_e'(i_rx_byte.data);
	assign cmd_accept = i_rx_byte.valid && (state != CHIP_RESET);  // Deaf during chip reset
	assign run_lvl    = (state == RUN);

	// ======================================================================
	// Control FSM
	// ======================================================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state   <= IDLE;
			rst_cnt <= '0;
		end else begin
			case (state)
				CHIP_RESET: begin
					if (rst_cnt == rst_cnt_t'(RESET_CYCLES - 1)) state <= IDLE;
					else rst_cnt <= rst_cnt + 1'b1;
				end
				default: begin  // IDLE and RUN decode alike
					if (cmd_accept) begin
						case (cmd)
							CMD_RESET: begin
								state   <= CHIP_RESET;
								rst_cnt <= '0;
							end
							CMD_START: state <= RUN;
							CMD_STOP:  state <= IDLE;
							default:   ;  // Status handled below, others ignored
						endcase
					end
				end
			endcase
		end
	end

	// ======================================================================
	// Status request, frame byte count, overruns
	// ======================================================================
	assign frame_accept = i_frame.valid && (byte_cnt == '0);
	assign send_status  = status_req && !i_tx_busy;                     // Status wins
	assign send_frame   = !status_req && (byte_cnt != '0) && !i_tx_busy;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			status_req  <= 1'b0;
			byte_cnt    <= '0;
			overrun_cnt <= '0;
		end else begin
			if (cmd_accept && cmd == CMD_STATUS) status_req <= 1'b1;
			else if (send_status) status_req <= 1'b0;

			if (frame_accept) byte_cnt <= byte_cnt_t'(FRAME_BYTES);
			else if (send_frame) byte_cnt <= byte_cnt - 1'b1;

			if (cmd_accept && cmd == CMD_RESET)
				overrun_cnt <= '0;
			else if (i_frame.valid && byte_cnt != '0 && overrun_cnt != 7'h7f)
				overrun_cnt <= overrun_cnt + 1'b1;  // Previous frame still going out
		end
	end

	// Frame latch, shifted up one byte per strobe
	always_ff @(posedge i_clk) begin
		if (frame_accept) frame_buf <= i_frame.data;
		else if (send_frame) frame_buf <= frame_buf << 8;
	end

	assign o_tx_byte = '{
		valid: send_status || send_frame,
		data:  status_req ? {run_lvl, overrun_cnt} : frame_buf[FRAME_BITS-1 -: 8]
	};
	assign o_run         = run_lvl;
	assign o_ads_start   = run_lvl;
	assign o_ads_reset_n = (state != CHIP_RESET);

	// Strobe only into an idle transmitter, which then goes busy
	a_tx_strobe_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		o_tx_byte.valid |-> !i_tx_busy ##1 i_tx_busy)
		else $error("sensor_core: tx strobe against busy transmitter");

endmodule

//--- design/ads1292_spi.sv
// ADS1292 frame reader, DRDY falling edge starts a 72-bit SPI mode-1 read
`timescale 1ns/1ps

module ads1292_spi import sensor_hub_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_run,
	input  logic       i_spi_miso,
	input  logic       i_ads_drdy_n,
	output ads_frame_t o_frame,
	output logic       o_spi_clk,
	output logic       o_spi_mosi,
	output logic       o_spi_csn
);

	typedef enum logic [1:0] {SPI_IDLE, SPI_READ, SPI_DONE} spi_state_e;
	typedef logic [$clog2(SPI_HALF_PERIOD)-1:0] half_cnt_t;
	typedef logic [$clog2(FRAME_BITS)-1:0]      bit_cnt_t;

	spi_state_e            state;
	half_cnt_t             half_cnt;    // Clocks within SCLK half period
	bit_cnt_t              bit_cnt;     // Bits sampled so far
	logic                  half_tick;   // SCLK toggles this cycle
	logic                  sclk;
	logic                  csn;
	logic                  frame_valid;
	logic [FRAME_BITS-1:0] shreg;       // MSB arrives first
	logic                  drdy_meta;
	logic                  drdy_sync;
	logic                  drdy_prev;
	logic                  drdy_fall;

	// ======================================================================
	// DRDY synchronizer and edge detect
	// ======================================================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			drdy_meta <= 1'b1;  // Not ready
			drdy_sync <= 1'b1;
			drdy_prev <= 1'b1;
		end else begin
			drdy_meta <= i_ads_drdy_n;
			drdy_sync <= drdy_meta;
			drdy_prev <= drdy_sync;
		end
	end

	assign drdy_fall = drdy_prev & ~drdy_sync;  // New sample in the chip

	// ======================================================================
	// SCLK generation and read sequencing
	// ======================================================================
	assign half_tick = (half_cnt == half_cnt_t'(SPI_HALF_PERIOD - 1));

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state       <= SPI_IDLE;
			half_cnt    <= '0;
			bit_cnt     <= '0;
			sclk        <= 1'b0;  // CPOL 0
			csn         <= 1'b1;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			case (state)
				SPI_IDLE: begin
					half_cnt <= '0;
					bit_cnt  <= '0;
					if (drdy_fall && i_run) begin
						csn   <= 1'b0;  // Select chip, SCLK starts low
						state <= SPI_READ;
					end
				end
				SPI_READ: begin
					if (half_tick) begin
						half_cnt <= '0;
						sclk     <= ~sclk;
						// Falling SCLK, bit sampled below
						if (sclk) begin
							if (bit_cnt == bit_cnt_t'(FRAME_BITS - 1)) begin
								csn   <= 1'b1;  // Last bit in
								state <= SPI_DONE;
							end else
								bit_cnt <= bit_cnt + 1'b1;
						end
					end else
						half_cnt <= half_cnt + 1'b1;
				end
				SPI_DONE: begin
					frame_valid <= 1'b1;  // One cycle after CSN rises
					state       <= SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// Mode 1: chip shifts on rising SCLK, sample on falling
	always_ff @(posedge i_clk) begin
		if (state == SPI_READ && half_tick && sclk)
			shreg <= {shreg[FRAME_BITS-2:0], i_spi_miso};
	end

	assign o_frame    = '{valid: frame_valid, data: shreg};
	assign o_spi_clk  = sclk;
	assign o_spi_csn  = csn;
	assign o_spi_mosi = 1'b0;  // Read only path, DIN held low

	a_sclk_low_deselected: assert property (@(posedge i_clk) disable iff (i_reset)
		o_spi_csn |-> !o_spi_clk)
		else $error("ads1292_spi: SCLK high while CSN high");

	a_csn_fall_from_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		$fell(o_spi_csn) |-> $past(state) == SPI_IDLE)
		else $error("ads1292_spi: CSN fell during a read");

endmodule

//--- design/uart_rx.sv
// UART receiver, 8N1, one byte strobe per good frame
`timescale 1ns/1ps

module uart_rx import sensor_hub_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_uart_rxd,
	output uart_byte_t o_rx_byte
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
	typedef logic [$clog2(CLKS_PER_BIT)-1:0] clk_cnt_t;

	rx_state_e  state;
	clk_cnt_t   clk_cnt;       // Cycles within current bit
	logic [2:0] bit_cnt;       // Data bit index
	logic       rxd_meta;
	logic       rxd_sync;
	logic [7:0] shreg;         // LSB first shift in
	logic       rx_valid;
	logic       bit_tick;      // Middle of a data or stop bit

	// Two-flop synchronizer, line idles high
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= i_uart_rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign bit_tick = (clk_cnt == clk_cnt_t'(CLKS_PER_BIT - 1));

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;  // Single cycle strobe
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					if (!rxd_sync) state <= RX_START;  // Start edge
				end
				// Half a bit to the middle of start, detect cycle already spent
				RX_START: begin
					if (clk_cnt == clk_cnt_t'(CLKS_PER_BIT / 2 - 2)) begin
						clk_cnt <= '0;
						state   <= rxd_sync ? RX_IDLE : RX_DATA;  // Glitch rejected
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_DATA: begin
					if (bit_tick) begin
						clk_cnt <= '0;
						if (bit_cnt == 3'd7) state <= RX_STOP;
						else bit_cnt <= bit_cnt + 1'b1;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_STOP: begin
					if (bit_tick) begin
						state    <= RX_IDLE;
						rx_valid <= rxd_sync;  // Framing error drops the byte
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data bits land here, held until the next frame
	always_ff @(posedge i_clk) begin
		if (state == RX_DATA && bit_tick) shreg <= {rxd_sync, shreg[7:1]};
	end

	assign o_rx_byte = '{valid: rx_valid, data: shreg};

	a_rx_single_strobe: assert property (@(posedge i_clk) disable iff (i_reset)
		o_rx_byte.valid |=> !o_rx_byte.valid)
		else $error("uart_rx: valid held for two cycles");

endmodule

//--- design/sensor_hub_pkg.sv
// Sensor hub shared definitions: timing constants, host opcodes, core states and bus structs
package sensor_hub_pkg;

	// ======================================================================
	// Timing constants
	// ======================================================================
	localparam int CLKS_PER_BIT    = 16;   // UART bit time, small for simulation
	localparam int SPI_HALF_PERIOD = 2;    // Clocks per SCLK half period
	localparam int FRAME_BITS      = 72;   // 24 status + 2 x 24 channel bits
	localparam int FRAME_BYTES     = 9;    // FRAME_BITS / 8
	localparam int RESET_CYCLES    = 32;   // ADS1292 RESET pin low time

	// ======================================================================
	// Enums
	// ======================================================================
	// One-byte host commands, anything else is ignored
	typedef enum logic [7:0] {
		CMD_RESET  = 8'h06,  // Pulse chip reset, clear run and overruns
		CMD_START  = 8'h08,  // Raise START, enable frame reads
		CMD_STOP   = 8'h0A,  // Drop START
		CMD_STATUS = 8'h20   // Reply with {run, overrun count}
	} ads_cmd_e;

	// Core control states
	typedef enum logic [1:0] {
		IDLE,        // Chip stopped
		CHIP_RESET,  // RESET pin held low, commands ignored
		RUN          // START high, frames streamed
	} core_state_e;

	// ======================================================================
	// Structs
	// ======================================================================
	// UART byte with a one-cycle strobe
	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} uart_byte_t;

	// Full ADS1292 data frame, status word in the top 24 bits
	typedef struct packed {
		logic                  valid;
		logic [FRAME_BITS-1:0] data;
	} ads_frame_t;

endpackage
